// File: pkt_pkg.sv
// stream widths, default buffer and fifo depths, framing state type
package pkt_pkg;

   ////////////////////
   // stream word layout
   ////////////////////

   // data bits per stream word
   parameter int DATA_WIDTH = 64;

   // one control bit per data byte
   parameter int CTRL_WIDTH = DATA_WIDTH / 8;

   // stored word is control on top of data
   parameter int WORD_WIDTH = CTRL_WIDTH + DATA_WIDTH;

   ////////////////////
   // default depths
   ////////////////////

   // log2 of buffer memory depth, 256 words
   parameter int DEFAULT_BUF_ADDR_WIDTH = 8;

   // log2 of input fifo depth, 4 words
   parameter int DEFAULT_FIFO_DEPTH_BITS = 2;

   ////////////////////
   // framing states
   ////////////////////

   // idle    waiting for a nonzero-control header word
   // payload storing words up to the next nonzero-control word
   // drain   ingress stopped, buffer emptied to the output
   typedef enum logic [1:0] {
      ST_IDLE    = 2'b00,
      ST_PAYLOAD = 2'b01,
      ST_DRAIN   = 2'b10
   } frame_state_t;

endpackage

// File: input_fifo.sv
// fall-through word fifo with empty and nearly-full flags
`timescale 1ns/100ps

module input_fifo #(
   parameter int FIFO_DEPTH_BITS = pkt_pkg::DEFAULT_FIFO_DEPTH_BITS
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          wr_en_i,
   input  logic [pkt_pkg::WORD_WIDTH-1:0] din_i,
   input  logic                          rd_en_i,
   output logic [pkt_pkg::WORD_WIDTH-1:0] dout_o,
   output logic                          empty_o,
   output logic                          nearly_full_o
);

   import pkt_pkg::*;

   localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

   // one free entry left
   localparam logic [FIFO_DEPTH_BITS:0] NF_LEVEL = (FIFO_DEPTH_BITS + 1)'(DEPTH - 1);

   ////////////////////
   // storage
   ////////////////////

   logic [WORD_WIDTH-1:0]      mem [DEPTH];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr_q;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr_q;
   // one extra bit so full and empty differ
   logic [FIFO_DEPTH_BITS:0]   count_q;

   // payload array, written at the tail
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr_q] <= din_i;
      end
   end

   ////////////////////
   // pointers and fill level
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         // pointers wrap on their own, depth is a power of two
         if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // head word shows without a read, valid whenever not empty
   assign dout_o        = mem[rd_ptr_q];
   assign empty_o       = (count_q == '0);
   // early warning, covers the word taken while ready falls
   assign nearly_full_o = (count_q >= NF_LEVEL);

endmodule

// File: frame_decode.sv
// framing fsm, fifo read control, buffer write request, ingress ready
`timescale 1ns/100ps

module frame_decode (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [pkt_pkg::WORD_WIDTH-1:0] fifo_word_i,
   input  logic                          fifo_empty_i,
   input  logic                          fifo_nearly_full_i,
   input  logic                          drain_done_i,
   output logic                          fifo_rd_o,
   output logic                          buf_wr_o,
   output logic [pkt_pkg::WORD_WIDTH-1:0] buf_word_o,
   output logic                          drain_o,
   output logic                          in_rdy_o
);

   import pkt_pkg::*;

   frame_state_t state_q;
   frame_state_t state_d;

   // control byte sits above the data in the fifo word
   logic [CTRL_WIDTH-1:0] head_ctrl;
   logic                  head_is_ctrl;

   assign head_ctrl    = fifo_word_i[WORD_WIDTH-1 -: CTRL_WIDTH];
   assign head_is_ctrl = (head_ctrl != '0);

   ////////////////////
   // next state
   ////////////////////

   always_comb begin
      state_d   = state_q;
      fifo_rd_o = 1'b0;
      buf_wr_o  = 1'b0;
      case (state_q)
         ST_IDLE: begin
            // pop everything, keep only a header
            if (!fifo_empty_i) begin
               fifo_rd_o = 1'b1;
               if (head_is_ctrl) begin
                  buf_wr_o = 1'b1;
                  state_d  = ST_PAYLOAD;
               end
            end
         end
         ST_PAYLOAD: begin
            if (!fifo_empty_i) begin
               fifo_rd_o = 1'b1;
               buf_wr_o  = 1'b1;
               // nonzero control again marks the end word
               if (head_is_ctrl) begin
                  state_d = ST_DRAIN;
               end
            end
         end
         ST_DRAIN: begin
            // fifo untouched until buffer is empty
            if (drain_done_i) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   ////////////////////
   // state register
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // word goes to the buffer in the same cycle it is popped
   assign buf_word_o = fifo_word_i;
   assign drain_o    = (state_q == ST_DRAIN);

   // ingress closes as soon as the end word is taken
   assign in_rdy_o = !fifo_nearly_full_i && (state_d != ST_DRAIN);

endmodule

// File: packet_buffer.sv
// dual-port packet buffer memory, registered read port, write pointer
`timescale 1ns/100ps

module packet_buffer #(
   parameter int BUF_ADDR_WIDTH = pkt_pkg::DEFAULT_BUF_ADDR_WIDTH
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          wr_en_i,
   input  logic [pkt_pkg::WORD_WIDTH-1:0] wr_word_i,
   input  logic [BUF_ADDR_WIDTH-1:0]     rd_addr_i,
   output logic [pkt_pkg::WORD_WIDTH-1:0] rd_word_o,
   output logic [BUF_ADDR_WIDTH-1:0]     wr_ptr_o
);

   import pkt_pkg::*;

   localparam int DEPTH = 2 ** BUF_ADDR_WIDTH;

   ////////////////////
   // memory array
   ////////////////////

   // ring of stored words, control over data
   logic [WORD_WIDTH-1:0]     mem [DEPTH];

   // tail of the ring
   logic [BUF_ADDR_WIDTH-1:0] wr_ptr_q;

   // read data register
   logic [WORD_WIDTH-1:0]     rd_word_q;

   ////////////////////
   // write port
   ////////////////////

   // word lands at the current tail
   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr_q] <= wr_word_i;
      end
   end

   // tail moves on the same edge as the write
   // wraps at depth, no overflow check here
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
      end else if (wr_en_i) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   ////////////////////
   // read port
   ////////////////////

   // one cycle from address to data
   // reads run every cycle, the drain side marks valid ones
   // writes and drain never overlap, so no bypass needed
   always_ff @(posedge clk) begin
      rd_word_q <= mem[rd_addr_i];
   end

   assign rd_word_o = rd_word_q;

   // drain compares its read pointer against this
   assign wr_ptr_o  = wr_ptr_q;

endmodule

// File: egress_drain.sv
// buffer read pointer, registered output strobe, drain-complete flag
`timescale 1ns/100ps

module egress_drain #(
   parameter int BUF_ADDR_WIDTH = pkt_pkg::DEFAULT_BUF_ADDR_WIDTH
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      drain_i,
   input  logic [BUF_ADDR_WIDTH-1:0] wr_ptr_i,
   input  logic                      out_rdy_i,
   output logic [BUF_ADDR_WIDTH-1:0] rd_addr_o,
   output logic                      drain_done_o,
   output logic                      out_wr_o
);

   ////////////////////
   // read issue
   ////////////////////

   // head of the ring
   logic [BUF_ADDR_WIDTH-1:0] rd_ptr_q;
   logic                      issue;
   // strobe delayed to meet the memory read latency
   logic                      out_wr_q;

   // caught up with the writer, nothing left to send
   assign drain_done_o = (rd_ptr_q == wr_ptr_i);

   // ready low stops new reads right away
   // the word already read still goes out next cycle
   assign issue = drain_i && !drain_done_o && out_rdy_i;

   assign rd_addr_o = rd_ptr_q;

   ////////////////////
   // pointer and strobe
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr_q <= '0;
         out_wr_q <= 1'b0;
      end else begin
         // one word per issued read
         out_wr_q <= issue;
         if (issue) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // lines up with the registered memory output
   assign out_wr_o = out_wr_q;

endmodule

// File: store_forward_top.sv
// store-and-forward top, fifo, framing decode, buffer and drain
`timescale 1ns/100ps

module store_forward_top #(
   parameter int BUF_ADDR_WIDTH  = pkt_pkg::DEFAULT_BUF_ADDR_WIDTH,
   parameter int FIFO_DEPTH_BITS = pkt_pkg::DEFAULT_FIFO_DEPTH_BITS
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [pkt_pkg::DATA_WIDTH-1:0] in_data_i,
   input  logic [pkt_pkg::CTRL_WIDTH-1:0] in_ctrl_i,
   input  logic                          in_wr_i,
   output logic                          in_rdy_o,
   output logic [pkt_pkg::DATA_WIDTH-1:0] out_data_o,
   output logic [pkt_pkg::CTRL_WIDTH-1:0] out_ctrl_o,
   output logic                          out_wr_o,
   input  logic                          out_rdy_i
);

   import pkt_pkg::*;

   ////////////////////
   // internal wires
   ////////////////////

   // fifo head to decode
   logic [WORD_WIDTH-1:0]     fifo_word;
   logic                      fifo_empty;
   logic                      fifo_nearly_full;
   logic                      fifo_rd;

   // decode to buffer
   logic                      buf_wr;
   logic [WORD_WIDTH-1:0]     buf_word;

   // buffer and drain
   logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
   logic [BUF_ADDR_WIDTH-1:0] rd_addr;
   logic [WORD_WIDTH-1:0]     rd_word;
   logic                      drain;
   logic                      drain_done;

   // words offered while not ready are dropped here
   input_fifo #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_input_fifo (
      .clk           (clk),
      .reset         (reset),
      .wr_en_i       (in_wr_i & in_rdy_o),
      .din_i         ({in_ctrl_i, in_data_i}),
      .rd_en_i       (fifo_rd),
      .dout_o        (fifo_word),
      .empty_o       (fifo_empty),
      .nearly_full_o (fifo_nearly_full)
   );

   frame_decode u_frame_decode (
      .clk                (clk),
      .reset              (reset),
      .fifo_word_i        (fifo_word),
      .fifo_empty_i       (fifo_empty),
      .fifo_nearly_full_i (fifo_nearly_full),
      .drain_done_i       (drain_done),
      .fifo_rd_o          (fifo_rd),
      .buf_wr_o           (buf_wr),
      .buf_word_o         (buf_word),
      .drain_o            (drain),
      .in_rdy_o           (in_rdy_o)
   );

   packet_buffer #(.BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) u_packet_buffer (
      .clk       (clk),
      .reset     (reset),
      .wr_en_i   (buf_wr),
      .wr_word_i (buf_word),
      .rd_addr_i (rd_addr),
      .rd_word_o (rd_word),
      .wr_ptr_o  (wr_ptr)
   );

   egress_drain #(.BUF_ADDR_WIDTH(BUF_ADDR_WIDTH)) u_egress_drain (
      .clk          (clk),
      .reset        (reset),
      .drain_i      (drain),
      .wr_ptr_i     (wr_ptr),
      .out_rdy_i    (out_rdy_i),
      .rd_addr_o    (rd_addr),
      .drain_done_o (drain_done),
      .out_wr_o     (out_wr_o)
   );

   // stored word splits back into control and data
   assign {out_ctrl_o, out_data_o} = rd_word;

endmodule

// File: store_forward_asserts.sv
// bound assertions on store_forward_top output strobe and buffer write control
`timescale 1ns/100ps

module store_forward_asserts (
   input logic clk,
   input logic reset,
   input logic out_wr_i,
   input logic out_rdy_i,
   input logic buf_wr_i,
   input logic drain_i
);

   // failures so far, picked up by the testbench summary
   int fail_count = 0;

   // strobe register cleared by reset
   a_quiet_after_reset: assert property (@(posedge clk) $fell(reset) |-> !out_wr_i)
      else begin
         $error("out_wr_o high in the first cycle after reset");
         fail_count++;
      end

   // every output word was issued while downstream was ready
   a_wr_needs_rdy: assert property (@(posedge clk) disable iff (reset)
                                    out_wr_i |-> $past(out_rdy_i))
      else begin
         $error("out_wr_o high without out_rdy_i in the previous cycle");
         fail_count++;
      end

   // ingress is frozen for the whole drain
   a_no_write_in_drain: assert property (@(posedge clk) disable iff (reset)
                                         !(buf_wr_i && drain_i))
      else begin
         $error("buffer write while draining");
         fail_count++;
      end

endmodule

bind store_forward_top store_forward_asserts u_store_forward_asserts (
   .clk       (clk),
   .reset     (reset),
   .out_wr_i  (out_wr_o),
   .out_rdy_i (out_rdy_i),
   .buf_wr_i  (buf_wr),
   .drain_i   (drain)
);

// File: tb_store_forward.sv
// testbench for store_forward_top, directed packet tests, output scoreboard, timeout, summary
`timescale 1ns/100ps

module tb_store_forward;

   import pkt_pkg::*;

   // about ten times the total length of the tests
   localparam int MAX_CYCLES = 4000;
   localparam logic [CTRL_WIDTH-1:0] HDR_CTRL = 8'hff;
   localparam logic [CTRL_WIDTH-1:0] END_CTRL = 8'h80;

   logic                  clk = 1'b0;
   logic                  reset;
   logic [DATA_WIDTH-1:0] in_data;
   logic [CTRL_WIDTH-1:0] in_ctrl;
   logic                  in_wr;
   logic                  in_rdy;
   logic [DATA_WIDTH-1:0] out_data;
   logic [CTRL_WIDTH-1:0] out_ctrl;
   logic                  out_wr;
   logic                  out_rdy = 1'b1;

   // words still owed by the DUT
   // control sits above data
   logic [WORD_WIDTH-1:0] exp_q [$];
   int errors   = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int cycles   = 0;
   int seed     = 22;
   bit rand_rdy = 1'b0;

   always #20 clk = ~clk;

   store_forward_top #(
      .BUF_ADDR_WIDTH  (DEFAULT_BUF_ADDR_WIDTH),
      .FIFO_DEPTH_BITS (DEFAULT_FIFO_DEPTH_BITS)
   ) uut (
      .clk        (clk),
      .reset      (reset),
      .in_data_i  (in_data),
      .in_ctrl_i  (in_ctrl),
      .in_wr_i    (in_wr),
      .in_rdy_o   (in_rdy),
      .out_data_o (out_data),
      .out_ctrl_o (out_ctrl),
      .out_wr_o   (out_wr),
      .out_rdy_i  (out_rdy)
   );

   ////////////////////
   // scoreboard
   ////////////////////

   // outputs settle after posedge and are sampled half a cycle later
   always @(negedge clk) begin
      logic [WORD_WIDTH-1:0] exp_word;
      if (!reset && out_wr) begin
         if (exp_q.size() == 0) begin
            $display("ERROR: out_wr_o pulsed with no word left to expect");
            errors++;
         end else begin
            exp_word = exp_q.pop_front();
            if (out_ctrl != exp_word[WORD_WIDTH-1 -: CTRL_WIDTH]) begin
               $display("ERROR: out_ctrl_o got %h expected %h",
                        out_ctrl, exp_word[WORD_WIDTH-1 -: CTRL_WIDTH]);
               errors++;
            end
            if (out_data != exp_word[DATA_WIDTH-1:0]) begin
               $display("ERROR: out_data_o got %h expected %h",
                        out_data, exp_word[DATA_WIDTH-1:0]);
               errors++;
            end
         end
      end
   end

   // downstream ready is random only in the back-pressure test
   always @(negedge clk) begin
      int rnd;
      if (rand_rdy) begin
         rnd = $random(seed);
         out_rdy = rnd[0];
      end else begin
         out_rdy = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, run still going after %0d cycles", MAX_CYCLES);
         $display("test failed");
         $finish;
      end
   end

   ////////////////////
   // stimulus helpers
   ////////////////////

   // tag each word with packet number and position
   function automatic logic [DATA_WIDTH-1:0] word_data(input int pkt, input int idx);
      return {16'hface, pkt[15:0], idx[31:0]};
   endfunction

   // holds the word until in_rdy_o lets it in
   task automatic send_word(input logic [CTRL_WIDTH-1:0] ctrl,
                            input logic [DATA_WIDTH-1:0] data, input bit keep);
      @(negedge clk);
      while (!in_rdy) begin
         in_wr = 1'b0;
         @(negedge clk);
      end
      in_wr   = 1'b1;
      in_ctrl = ctrl;
      in_data = data;
      if (keep) begin
         exp_q.push_back({ctrl, data});
      end
   endtask

   task automatic close_burst;
      @(negedge clk);
      in_wr = 1'b0;
   endtask

   // header, payload of zero control, end word
   task automatic send_packet(input int pkt, input int n_payload);
      send_word(HDR_CTRL, word_data(pkt, 0), 1'b1);
      for (int i = 1; i <= n_payload; i++) begin
         send_word('0, word_data(pkt, i), 1'b1);
      end
      send_word(END_CTRL, word_data(pkt, n_payload + 1), 1'b1);
   endtask

   task automatic wait_drained;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      // a few more cycles so extra words would show up
      repeat (4) @(negedge clk);
   endtask

   task automatic report_test(input string name, input int err_start);
      if (!in_rdy) begin
         $display("ERROR: in_rdy_o got %h expected %h", in_rdy, 1'b1);
         errors++;
      end
      if (errors == err_start) begin
         pass_cnt++;
         $display("%-24s ok", name);
      end else begin
         fail_cnt++;
         $display("%-24s %0d mismatches", name, errors - err_start);
      end
   endtask

   ////////////////////
   // directed tests
   ////////////////////

   task automatic single_packet;
      int err_start;
      err_start = errors;
      send_packet(1, 6);
      close_burst();
      wait_drained();
      report_test("single packet", err_start);
   endtask

   task automatic idle_words_dropped;
      int err_start;
      err_start = errors;
      // zero-control words before a header are never stored
      for (int i = 0; i < 3; i++) begin
         send_word('0, word_data(99, i), 1'b0);
      end
      send_packet(2, 4);
      close_burst();
      wait_drained();
      report_test("idle words dropped", err_start);
   endtask

   task automatic minimal_packet;
      int err_start;
      err_start = errors;
      send_packet(3, 0);
      close_burst();
      wait_drained();
      report_test("header and end only", err_start);
   endtask

   task automatic back_to_back_packets;
      int err_start;
      err_start = errors;
      send_packet(4, 3);
      send_packet(5, 5);
      send_packet(6, 2);
      close_burst();
      wait_drained();
      report_test("back to back packets", err_start);
   endtask

   task automatic random_out_ready;
      int err_start;
      err_start = errors;
      rand_rdy = 1'b1;
      send_packet(7, 7);
      send_packet(8, 4);
      close_burst();
      wait_drained();
      rand_rdy = 1'b0;
      report_test("random out ready", err_start);
   endtask

   initial begin
      reset   = 1'b1;
      in_wr   = 1'b0;
      in_ctrl = '0;
      in_data = '0;
      repeat (10) @(negedge clk);
      reset = 1'b0;
      single_packet();
      idle_words_dropped();
      minimal_packet();
      back_to_back_packets();
      random_out_ready();
      $display("summary: %0d tests ok, %0d tests with errors, %0d assertion failures",
               pass_cnt, fail_cnt, uut.u_store_forward_asserts.fail_count);
      if (fail_cnt == 0 && uut.u_store_forward_asserts.fail_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: files.f
pkt_pkg.sv
input_fifo.sv
frame_decode.sv
packet_buffer.sv
egress_drain.sv
store_forward_top.sv
store_forward_asserts.sv
tb_store_forward.sv

// File: run.sh
#!/bin/sh
# build and run the store-and-forward testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_store_forward -f files.f -o sim_store_forward \
   && ./obj_dir/sim_store_forward +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
